// ==== verilog/exu_pkg.sv ====
package exu_pkg;

	// datapath widths
	localparam int xlen    = 32;
	localparam int reg_dig = 5; // register index bits

	// link offset for jal/jalr
	localparam int unsigned word_bytes = 4;

	// alu and branch compare codes
	// the compare codes leave the result at zero and only drive the branch flag
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9,
		alu_eq   = 4'd10, // beq
		alu_neq  = 4'd11, // bne
		alu_lt   = 4'd12, // blt
		alu_ge   = 4'd13, // bge
		alu_ltu  = 4'd14, // bltu
		alu_geu  = 4'd15  // bgeu
	} alu_op_t;

	// shift amount field of src2
	localparam int shamt_w = 5;

endpackage

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

	// load kinds, no_mem_read marks a non-load op
	typedef enum logic [2:0] {
		no_mem_read = 3'd0,
		lb          = 3'd1,
		lh          = 3'd2,
		lw          = 3'd3,
		lbu         = 3'd4,
		lhu         = 3'd5
	} lsu_read_t;

	// store kinds
	typedef enum logic [1:0] {
		no_mem_write = 2'd0,
		sb           = 2'd1,
		sh           = 2'd2,
		sw           = 2'd3
	} lsu_write_t;

endpackage

// ==== verilog/exu_dispatch.sv ====
module exu_dispatch #(
	parameter int lanes = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  logic [lanes-1:0] busy,
	output logic             in_ready,
	output logic [lanes-1:0] issue
);

	// pointer needs at least one bit even for a single lane
	localparam int ptr_w = (lanes > 1) ? $clog2(lanes) : 1;

	logic [ptr_w-1:0] wr_ptr;
	logic             accept;

	// grant only when the lane in turn has drained
	assign in_ready = ~busy[wr_ptr];
	assign accept   = in_valid & in_ready;

	// one-hot strobe for the lane at the write pointer
	always_comb begin
		issue         = '0;
		issue[wr_ptr] = accept;
	end

	// round-robin write pointer, wraps at lanes
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (accept) begin
			if (wr_ptr == ptr_w'(lanes - 1))
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

endmodule

// ==== verilog/exu_lane.sv ====
module exu_lane import exu_pkg::*, lsu_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue,
	input  logic               release_stb,
	input  logic [xlen-1:0]    pc,
	input  logic [xlen-1:0]    src1,
	input  logic [xlen-1:0]    src2,
	input  logic [xlen-1:0]    imm,
	input  alu_op_t            alu_op,
	input  logic               is_jalr,
	input  logic               is_jump,
	input  logic               ecall,
	input  logic               mret,
	input  logic               reg_write,
	input  logic [reg_dig-1:0] rd,
	input  lsu_read_t          lsu_read,
	input  lsu_write_t         lsu_write,
	input  logic [xlen-1:0]    lsu_wdata,
	output logic               busy,
	output logic [xlen-1:0]    result,
	output logic [xlen-1:0]    branch_target,
	output logic [xlen-1:0]    lsu_wdata_out,
	output logic               branch_taken,
	output logic               reg_write_out,
	output logic               fwd_valid,
	output logic [reg_dig-1:0] rd_out,
	output lsu_read_t          lsu_read_out,
	output lsu_write_t         lsu_write_out
);

	logic [xlen-1:0]    alu_res;
	logic               cmp_hit; // branch compare outcome
	logic [xlen-1:0]    target;
	logic [shamt_w-1:0] shamt;
	logic [xlen-1:0]    link;

	assign shamt = src2[shamt_w-1:0];

	// jal/jalr link value, ecall keeps the pc itself
	assign link = ecall ? pc : pc + xlen'(word_bytes);

	always_comb begin
		alu_res = '0;
		cmp_hit = 1'b0;
		case (alu_op)
			alu_add:  alu_res = is_jalr ? link : src1 + src2;
			alu_sub:  alu_res = src1 - src2;
			alu_sll:  alu_res = src1 << shamt;
			alu_slt:  alu_res = xlen'($signed(src1) < $signed(src2));
			alu_sltu: alu_res = xlen'(src1 < src2);
			alu_xor:  alu_res = src1 ^ src2;
			alu_srl:  alu_res = src1 >> shamt;
			alu_sra:  alu_res = $signed(src1) >>> shamt;
			alu_or:   alu_res = src1 | src2;
			alu_and:  alu_res = src1 & src2;
			alu_eq:   cmp_hit = (src1 == src2);
			alu_neq:  cmp_hit = (src1 != src2);
			alu_lt:   cmp_hit = ($signed(src1) < $signed(src2));
			alu_ge:   cmp_hit = ($signed(src1) >= $signed(src2));
			alu_ltu:  cmp_hit = (src1 < src2);
			alu_geu:  cmp_hit = (src1 >= src2);
			default:  alu_res = '0;
		endcase
	end

	// register-based target for jalr and mret, pc relative otherwise
	assign target = (is_jalr || mret) ? src1 + src2 : pc + imm;

	// slot occupancy
	always_ff @(posedge clk) begin
		if (rst)
			busy <= 1'b0;
		else if (issue)
			busy <= 1'b1;
		else if (release_stb)
			busy <= 1'b0; // retire took it
	end

	// held results, loaded on the issue edge only
	always_ff @(posedge clk) begin
		if (issue) begin
			result        <= alu_res;
			branch_taken  <= is_jump | cmp_hit;
			branch_target <= target;
			rd_out        <= rd;
			reg_write_out <= reg_write;
			lsu_read_out  <= lsu_read;
			lsu_write_out <= lsu_write;
			lsu_wdata_out <= lsu_wdata;
			fwd_valid     <= (lsu_read == no_mem_read); // loads cannot forward yet
		end
	end

endmodule

// ==== verilog/exu_retire.sv ====
module exu_retire import exu_pkg::*, lsu_pkg::*; #(
	parameter int lanes = 4
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [lanes-1:0]                   busy,
	input  logic [lanes*xlen-1:0]              result_vec,
	input  logic [lanes-1:0]                   branch_taken_vec,
	input  logic [lanes*xlen-1:0]              branch_target_vec,
	input  logic [lanes*reg_dig-1:0]           rd_vec,
	input  logic [lanes-1:0]                   reg_write_vec,
	input  logic [lanes*$bits(lsu_read_t)-1:0] lsu_read_vec,
	input  logic [lanes*$bits(lsu_write_t)-1:0] lsu_write_vec,
	input  logic [lanes*xlen-1:0]              lsu_wdata_vec,
	input  logic [lanes-1:0]                   fwd_valid_vec,
	input  logic                               out_ready,
	output logic                               out_valid,
	output logic [lanes-1:0]                   release_stb,
	output logic [xlen-1:0]                    result,
	output logic                               branch_taken,
	output logic [xlen-1:0]                    branch_target,
	output logic [reg_dig-1:0]                 rd_out,
	output logic                               reg_write_out,
	output lsu_read_t                          lsu_read_out,
	output lsu_write_t                         lsu_write_out,
	output logic [xlen-1:0]                    lsu_wdata_out,
	output logic                               fwd_valid
);

	localparam int ptr_w = (lanes > 1) ? $clog2(lanes) : 1;
	localparam int rd_w  = $bits(lsu_read_t);
	localparam int wr_w  = $bits(lsu_write_t);

	logic [ptr_w-1:0] rd_ptr; // oldest lane in flight
	logic             xfer;

	// head lane full means a result is ready
	assign out_valid = busy[rd_ptr];
	assign xfer      = out_valid & out_ready;

	always_comb begin
		release_stb         = '0;
		release_stb[rd_ptr] = xfer;
	end

	// field mux for the head lane
	assign result        = result_vec[rd_ptr*xlen +: xlen];
	assign branch_taken  = branch_taken_vec[rd_ptr];
	assign branch_target = branch_target_vec[rd_ptr*xlen +: xlen];
	assign rd_out        = rd_vec[rd_ptr*reg_dig +: reg_dig];
	assign reg_write_out = reg_write_vec[rd_ptr];
	assign lsu_read_out  = lsu_read_t'(lsu_read_vec[rd_ptr*rd_w +: rd_w]);
	assign lsu_write_out = lsu_write_t'(lsu_write_vec[rd_ptr*wr_w +: wr_w]);
	assign lsu_wdata_out = lsu_wdata_vec[rd_ptr*xlen +: xlen];
	assign fwd_valid     = fwd_valid_vec[rd_ptr];

	// same wrap order as the dispatcher keeps issue order
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (xfer) begin
			if (rd_ptr == ptr_w'(lanes - 1))
				rd_ptr <= '0;
			else
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

// ==== verilog/exu_cluster.sv ====
module exu_cluster import exu_pkg::*, lsu_pkg::*; #(
	parameter int lanes = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	output logic               in_ready,
	input  logic [xlen-1:0]    pc,
	input  logic [xlen-1:0]    src1,
	input  logic [xlen-1:0]    src2,
	input  logic [xlen-1:0]    imm,
	input  alu_op_t            alu_op,
	input  logic               is_jalr,
	input  logic               is_jump,
	input  logic               ecall,
	input  logic               mret,
	input  logic [reg_dig-1:0] rd,
	input  logic               reg_write,
	input  lsu_read_t          lsu_read,
	input  lsu_write_t         lsu_write,
	input  logic [xlen-1:0]    lsu_wdata,
	output logic               out_valid,
	input  logic               out_ready,
	output logic [xlen-1:0]    result,
	output logic               branch_taken,
	output logic [xlen-1:0]    branch_target,
	output logic [reg_dig-1:0] rd_out,
	output logic               reg_write_out,
	output lsu_read_t          lsu_read_out,
	output lsu_write_t         lsu_write_out,
	output logic [xlen-1:0]    lsu_wdata_out,
	output logic               fwd_valid
);

	localparam int rd_w = $bits(lsu_read_t);
	localparam int wr_w = $bits(lsu_write_t);

	logic [lanes-1:0] issue;
	logic [lanes-1:0] release_stb;
	logic [lanes-1:0] busy;

	// per lane results, flattened by field
	logic [lanes*xlen-1:0]    result_vec;
	logic [lanes-1:0]         branch_taken_vec;
	logic [lanes*xlen-1:0]    branch_target_vec;
	logic [lanes*reg_dig-1:0] rd_vec;
	logic [lanes-1:0]         reg_write_vec;
	logic [lanes*rd_w-1:0]    lsu_read_vec;
	logic [lanes*wr_w-1:0]    lsu_write_vec;
	logic [lanes*xlen-1:0]    lsu_wdata_vec;
	logic [lanes-1:0]         fwd_valid_vec;

	exu_dispatch #(.lanes(lanes)) u_dispatch (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.busy     (busy),
		.in_ready (in_ready),
		.issue    (issue)
	);

	for (genvar i = 0; i < lanes; i++) begin : g_lane
		exu_lane u_lane (
			.clk           (clk),
			.rst           (rst),
			.issue         (issue[i]),
			.release_stb   (release_stb[i]),
			.pc            (pc),
			.src1          (src1),
			.src2          (src2),
			.imm           (imm),
			.alu_op        (alu_op),
			.is_jalr       (is_jalr),
			.is_jump       (is_jump),
			.ecall         (ecall),
			.mret          (mret),
			.reg_write     (reg_write),
			.rd            (rd),
			.lsu_read      (lsu_read),
			.lsu_write     (lsu_write),
			.lsu_wdata     (lsu_wdata),
			.busy          (busy[i]),
			.result        (result_vec[i*xlen +: xlen]),
			.branch_target (branch_target_vec[i*xlen +: xlen]),
			.lsu_wdata_out (lsu_wdata_vec[i*xlen +: xlen]),
			.branch_taken  (branch_taken_vec[i]),
			.reg_write_out (reg_write_vec[i]),
			.fwd_valid     (fwd_valid_vec[i]),
			.rd_out        (rd_vec[i*reg_dig +: reg_dig]),
			.lsu_read_out  (lsu_read_vec[i*rd_w +: rd_w]),
			.lsu_write_out (lsu_write_vec[i*wr_w +: wr_w])
		);
	end

	exu_retire #(.lanes(lanes)) u_retire (
		.clk               (clk),
		.rst               (rst),
		.busy              (busy),
		.result_vec        (result_vec),
		.branch_taken_vec  (branch_taken_vec),
		.branch_target_vec (branch_target_vec),
		.rd_vec            (rd_vec),
		.reg_write_vec     (reg_write_vec),
		.lsu_read_vec      (lsu_read_vec),
		.lsu_write_vec     (lsu_write_vec),
		.lsu_wdata_vec     (lsu_wdata_vec),
		.fwd_valid_vec     (fwd_valid_vec),
		.out_ready         (out_ready),
		.out_valid         (out_valid),
		.release_stb       (release_stb),
		.result            (result),
		.branch_taken      (branch_taken),
		.branch_target     (branch_target),
		.rd_out            (rd_out),
		.reg_write_out     (reg_write_out),
		.lsu_read_out      (lsu_read_out),
		.lsu_write_out     (lsu_write_out),
		.lsu_wdata_out     (lsu_wdata_out),
		.fwd_valid         (fwd_valid)
	);

endmodule

// ==== sim/exu_cluster_assert.sv ====
module exu_cluster_assert import exu_pkg::*; #(
	parameter int lanes = 4
) (
	input logic             clk,
	input logic             rst,
	input logic             in_valid,
	input logic             in_ready,
	input logic [xlen-1:0]  pc,
	input logic [xlen-1:0]  src1,
	input logic [xlen-1:0]  src2,
	input alu_op_t          alu_op,
	input logic             out_valid,
	input logic             out_ready,
	input logic [xlen-1:0]  result,
	input logic [xlen-1:0]  branch_target,
	input logic [lanes-1:0] issue,
	input logic [lanes-1:0] release_stb,
	input logic [lanes-1:0] busy
);

	int unsigned fail_count = 0; // failed assertions so far

	// a stalled op stays on the input unchanged
	in_hold: assert property (@(posedge clk) disable iff (rst)
		in_valid && !in_ready |=> in_valid && $stable({pc, src1, src2, alu_op}))
		else begin
			$error("input op dropped or changed while in_ready was low");
			fail_count++;
		end

	out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable({result, branch_target}))
		else begin
			$error("output result dropped or changed while out_ready was low");
			fail_count++;
		end

	// cluster comes out of reset empty
	reset_empty: assert property (@(posedge clk) rst |=> !out_valid && busy == '0)
		else begin
			$error("out_valid or a lane busy in the cycle after reset");
			fail_count++;
		end

	// empty cluster gives a one cycle latency
	fast_path: assert property (@(posedge clk) disable iff (rst)
		in_valid && in_ready && busy == '0 |=> out_valid)
		else begin
			$error("out_valid missing one cycle after accept into an empty cluster");
			fail_count++;
		end

	// at most one strobe of each kind and busy follows the strobed lane
	strobes: assert property (@(posedge clk) disable iff (rst)
		$onehot0(issue) && $onehot0(release_stb)
		&& (busy & $past(issue)) == $past(issue)
		&& (busy & $past(release_stb)) == '0)
		else begin
			$error("issue or release strobe not one-hot or lane busy flag did not follow it");
			fail_count++;
		end

endmodule

// ==== sim/exu_cluster_tb.sv ====
module exu_cluster_tb import exu_pkg::*, lsu_pkg::*; ();

	localparam int lanes = 4;
	localparam int reset_ops = 4;
	localparam int alu_ops = 200;
	localparam int branch_ops = 22; // 6 compares x 3 pairs, 4 link cases
	localparam int pass_ops = 60;
	localparam int bp_ops = 24;
	localparam int all_ops = reset_ops + alu_ops + branch_ops + pass_ops + bp_ops;
	localparam int timeout_cycles = 4 * all_ops + 200;

	typedef struct packed {
		logic [xlen-1:0]    result;
		logic               taken;
		logic [xlen-1:0]    target;
		logic [reg_dig-1:0] rd;
		logic               reg_write;
		lsu_read_t          lsu_read;
		lsu_write_t         lsu_write;
		logic [xlen-1:0]    wdata;
		logic               fwd;
	} expect_t;

	logic clk, rst, in_valid, in_ready, out_valid, out_ready;
	logic [xlen-1:0] pc, src1, src2, imm, lsu_wdata;
	alu_op_t alu_op;
	logic is_jalr, is_jump, ecall, mret, reg_write;
	logic [reg_dig-1:0] rd;
	lsu_read_t lsu_read;
	lsu_write_t lsu_write;
	logic [xlen-1:0] result, branch_target, lsu_wdata_out;
	logic branch_taken, reg_write_out, fwd_valid;
	logic [reg_dig-1:0] rd_out;
	lsu_read_t lsu_read_out;
	lsu_write_t lsu_write_out;

	expect_t exp_q[$];
	int errors = 0;
	int checked = 0;
	int cycles = 0;
	logic [15:0] lfsr = 16'd58122;

	exu_cluster #(.lanes(lanes)) DUT (.*);

	bind exu_cluster exu_cluster_assert #(.lanes(lanes)) chk (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, %0d ops still outstanding", cycles, exp_q.size());
			$display("Done: errors found");
			$finish;
		end
	end

	// galois lfsr, x^16+x^14+x^13+x^11+1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
		return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000); // bias the sign bit
	endfunction

	// reference model of one lane, from the current input fields
	function automatic expect_t expected_now();
		expect_t e;
		logic [63:0] wide;
		logic cmp;
		e = '0;
		cmp = 1'b0;
		wide = {{32{src1[31]}}, src1} >> src2[4:0];
		case (alu_op)
			alu_add:  e.result = is_jalr ? (ecall ? pc : pc + 32'(word_bytes)) : src1 + src2;
			alu_sub:  e.result = src1 + ~src2 + 32'd1;
			alu_sll:  e.result = src1 << src2[4:0];
			alu_slt:  e.result = {31'd0, signed_less(src1, src2)};
			alu_sltu: e.result = {31'd0, src1 < src2};
			alu_xor:  e.result = src1 ^ src2;
			alu_srl:  e.result = src1 >> src2[4:0];
			alu_sra:  e.result = wide[31:0];
			alu_or:   e.result = src1 | src2;
			alu_and:  e.result = src1 & src2;
			alu_eq:   cmp = src1 == src2;
			alu_neq:  cmp = src1 != src2;
			alu_lt:   cmp = signed_less(src1, src2);
			alu_ge:   cmp = !signed_less(src1, src2);
			alu_ltu:  cmp = src1 < src2;
			default:  cmp = !(src1 < src2); // geu
		endcase
		e.taken = is_jump | cmp;
		e.target = (is_jalr || mret) ? src1 + src2 : pc + imm;
		e.rd = rd;
		e.reg_write = reg_write;
		e.lsu_read = lsu_read;
		e.lsu_write = lsu_write;
		e.wdata = lsu_wdata;
		e.fwd = lsu_read == no_mem_read;
		return e;
	endfunction

	function automatic void check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endfunction

	// scoreboard, pop on output transfer then push on accept
	always @(posedge clk) begin : scoreboard
		expect_t e;
		if (!rst && out_valid && out_ready) begin
			checked++;
			if (exp_q.size() == 0) begin
				$display("output transfer with no operation outstanding");
				errors++;
			end else begin
				e = exp_q.pop_front();
				check_field("result", result, e.result);
				check_field("branch_taken", 32'(branch_taken), 32'(e.taken));
				check_field("branch_target", branch_target, e.target);
				check_field("rd_out", 32'(rd_out), 32'(e.rd));
				check_field("reg_write_out", 32'(reg_write_out), 32'(e.reg_write));
				check_field("lsu_read_out", 32'(lsu_read_out), 32'(e.lsu_read));
				check_field("lsu_write_out", 32'(lsu_write_out), 32'(e.lsu_write));
				check_field("lsu_wdata_out", lsu_wdata_out, e.wdata);
				check_field("fwd_valid", 32'(fwd_valid), 32'(e.fwd));
			end
		end
		if (!rst && in_valid && in_ready)
			exp_q.push_back(expected_now());
	end

	// plain alu op with random operands
	task automatic base_fields();
		pc = rand_bits(32) & 32'hFFFF_FFFC;
		src1 = rand_bits(32);
		src2 = rand_bits(32);
		imm = rand_bits(32);
		alu_op = alu_add;
		is_jalr = 1'b0;
		is_jump = 1'b0;
		ecall = 1'b0;
		mret = 1'b0;
		rd = 5'(rand_bits(5));
		reg_write = 1'b1;
		lsu_read = no_mem_read;
		lsu_write = no_mem_write;
		lsu_wdata = '0;
	endtask

	task automatic control_fields();
		base_fields();
		alu_op = alu_op_t'(4'(rand_bits(4) % 10));
		reg_write = rand_bits(1) != 0;
		lsu_read = lsu_read_t'(3'(rand_bits(3) % 6));
		lsu_write = lsu_write_t'(2'(rand_bits(2)));
		lsu_wdata = rand_bits(32);
	endtask

	// called on a falling edge, returns on the falling edge after the accept
	task automatic send_current();
		in_valid = 1'b1;
		do @(posedge clk); while (!in_ready);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic report(input string name, input int n, input int err0);
		$display("test %s: %0d ops, %0d errors", name, n, errors - err0);
	endtask

	task automatic alu_test(input string name, input int n);
		int err0;
		err0 = errors;
		for (int i = 0; i < n; i++) begin
			base_fields();
			alu_op = alu_op_t'(4'(i % 10));
			send_current();
			if (rand_bits(2) == 0)
				@(negedge clk); // gap so the next op meets an empty cluster
		end
		drain();
		report(name, n, err0);
	endtask

	task automatic branch_test();
		logic [xlen-1:0] pa [3];
		logic [xlen-1:0] pb [3];
		int err0;
		err0 = errors;
		pa[0] = 32'h0000_0005;
		pb[0] = 32'h0000_0005;
		pa[1] = 32'hFFFF_FFFD; // less when signed, greater unsigned
		pb[1] = 32'h0000_0007;
		pa[2] = 32'h0000_0007;
		pb[2] = 32'hFFFF_FFFD;
		for (int c = 10; c < 16; c++) begin
			for (int p = 0; p < 3; p++) begin
				base_fields();
				alu_op = alu_op_t'(4'(c));
				src1 = pa[p];
				src2 = pb[p];
				send_current();
			end
		end
		base_fields();
		is_jump = 1'b1; // jal
		send_current();
		base_fields();
		is_jump = 1'b1;
		is_jalr = 1'b1;
		send_current();
		base_fields();
		is_jump = 1'b1;
		mret = 1'b1;
		send_current();
		base_fields();
		is_jalr = 1'b1;
		ecall = 1'b1;
		send_current();
		drain();
		report("branch", branch_ops, err0);
	endtask

	task automatic passthrough_test();
		int err0;
		err0 = errors;
		for (int i = 0; i < pass_ops; i++) begin
			control_fields();
			send_current();
			if (rand_bits(2) == 0)
				@(negedge clk);
		end
		drain();
		report("passthrough", pass_ops, err0);
	endtask

	task automatic backpressure_test();
		int err0;
		int sent;
		int cyc;
		logic accepted;
		err0 = errors;
		sent = 0;
		cyc = 0;
		out_ready = 1'b0;
		control_fields();
		in_valid = 1'b1;
		while (sent < bp_ops) begin
			@(posedge clk);
			accepted = in_ready;
			@(negedge clk);
			cyc++;
			if (accepted)
				sent++;
			if (cyc == 10) begin
				assert (sent == lanes && !in_ready) else begin
					$display("input not stalled after %0d accepts with output blocked", sent);
					errors++;
				end
			end
			if (cyc >= 10)
				out_ready = rand_bits(1) != 0;
			if (accepted && sent < bp_ops)
				control_fields();
			else if (accepted)
				in_valid = 1'b0;
		end
		out_ready = 1'b1;
		drain();
		report("backpressure", bp_ops, err0);
	endtask

	initial begin
		rst = 1'b1;
		out_ready = 1'b1;
		base_fields();
		in_valid = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		alu_test("reset", reset_ops);
		alu_test("alu", alu_ops);
		branch_test();
		passthrough_test();
		backpressure_test();
		$display("checked %0d transfers, %0d errors, %0d assertion failures",
			checked, errors, DUT.chk.fail_count);
		if (errors == 0 && DUT.chk.fail_count == 0 && checked == all_ops)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/exu_pkg.sv
verilog/lsu_pkg.sv
verilog/exu_dispatch.sv
verilog/exu_lane.sv
verilog/exu_retire.sv
verilog/exu_cluster.sv
sim/exu_cluster_assert.sv
sim/exu_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the exu_cluster testbench with Verilator, run it, check the log
verilator --binary --assert --top-module exu_cluster_tb -f flist.f -o exu_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/exu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "simulator returned a nonzero status"
cat sim.log
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
